// ==== Bender.yml ====
package:
  name: cpu48

sources:
  - files:
      - cpuPkg.sv
      - regFile.sv
      - fetchStage.sv
      - pipeControl.sv
      - executeStage.sv
      - memStage.sv
      - cpu.sv
  - target: test
    files:
      - tbClock.sv
      - cpuTb.sv

// ==== build.f ====
cpuPkg.sv
regFile.sv
fetchStage.sv
pipeControl.sv
executeStage.sv
memStage.sv
cpu.sv
tbClock.sv
cpuTb.sv

// ==== cpu.sv ====
`timescale 1ns/10ps

module cpu (
	input logic clk,
	input logic rstN,
	output cpuPkg::wordT pcF,
	input cpuPkg::instrT instr,
	output logic memWrite,
	output cpuPkg::wordT aluOut,
	output cpuPkg::wordT writeData,
	input cpuPkg::wordT readData
);
	import cpuPkg::*;

	// Decode stage
	instrT instrD;
	wordT pcD;
	ctrlT ctrlD;
	wordT immD;
	regAddrT ra1D;
	regAddrT ra2D;
	regAddrT wa3D;
	wordT rd1;
	wordT rd2;
	deT deD;

	// Hazard control
	logic stall;
	logic flushD;
	logic flushE;
	logic [1:0] forwardA;
	logic [1:0] forwardB;

	// Execute stage
	regAddrT raE1;
	regAddrT raE2;
	regAddrT wa3E;
	logic memToRegE;
	logic branchTaken;
	wordT branchTarget;
	emT emE;

	// Memory and writeback
	logic regWriteM;
	regAddrT wa3M;
	logic regWriteW;
	regAddrT wa3W;
	wordT resultW;

	assign deD.ctrl = ctrlD;
	assign deD.rnVal = rd1;
	assign deD.rmVal = rd2;
	assign deD.imm = immD;
	assign deD.ra1 = ra1D;
	assign deD.ra2 = ra2D;
	assign deD.wa3 = wa3D;
	assign deD.pc = pcD;

	pipeControl pipeControl_i (
		.clk(clk), .rstN(rstN), .instrD(instrD), .raE1(raE1), .raE2(raE2),
		.memToRegE(memToRegE), .wa3E(wa3E), .wa3M(wa3M), .wa3W(wa3W),
		.regWriteM(regWriteM), .regWriteW(regWriteW), .branchTaken(branchTaken),
		.ctrlD(ctrlD), .immD(immD), .ra1D(ra1D), .ra2D(ra2D), .wa3D(wa3D),
		.stall(stall), .flushD(flushD), .flushE(flushE),
		.forwardA(forwardA), .forwardB(forwardB)
	);

	fetchStage fetchStage_i (
		.clk(clk), .rstN(rstN), .stall(stall), .flushD(flushD),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .instr(instr),
		.pcF(pcF), .instrD(instrD), .pcD(pcD)
	);

	regFile regFile_i (
		.clk(clk), .rstN(rstN), .ra1(ra1D), .ra2(ra2D), .rd1(rd1), .rd2(rd2),
		.we(regWriteW), .wa(wa3W), .wd(resultW)
	);

	executeStage executeStage_i (
		.clk(clk), .rstN(rstN), .flushE(flushE), .deIn(deD),
		.forwardA(forwardA), .forwardB(forwardB), .aluOutM(aluOut), .resultW(resultW),
		.emOut(emE), .raE1(raE1), .raE2(raE2), .wa3E(wa3E), .memToRegE(memToRegE),
		.branchTaken(branchTaken), .branchTarget(branchTarget)
	);

	memStage memStage_i (
		.clk(clk), .rstN(rstN), .emIn(emE), .readData(readData),
		.memWrite(memWrite), .aluOut(aluOut), .writeData(writeData),
		.regWriteM(regWriteM), .wa3M(wa3M), .regWriteW(regWriteW), .wa3W(wa3W),
		.resultW(resultW)
	);

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

	localparam int wordWidth = 48;
	localparam int regCount = 32;

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [wordWidth-1:0] instrT;
	typedef logic [4:0] regAddrT;
	typedef logic [3:0] flagsT;
	typedef logic [1:0] aluCmdT;
	typedef logic [3:0] condT;

	// Instruction field positions
	localparam int condLsb = 44;
	localparam int opLsb = 41;
	localparam int immSelBit = 40;
	localparam int cmdLsb = 38;
	localparam int setFlagsBit = 37;
	localparam int loadBit = 36;
	localparam int rnLsb = 30;
	localparam int rdLsb = 25;
	localparam int rmLsb = 0;
	localparam int immMsb = 23;

	// Flag bit positions inside NZCV
	localparam int flagN = 3;
	localparam int flagZ = 2;
	localparam int flagC = 1;
	localparam int flagV = 0;

	localparam logic [2:0] opData = 3'd0;
	localparam logic [2:0] opMem = 3'd1;
	localparam logic [2:0] opBranch = 3'd2;

	localparam aluCmdT aluAdd = 2'd0;
	localparam aluCmdT aluSub = 2'd1;
	localparam aluCmdT aluAnd = 2'd2;
	localparam aluCmdT aluOrr = 2'd3;

	localparam condT condEq = 4'h0;
	localparam condT condNe = 4'h1;
	localparam condT condMi = 4'h4;
	localparam condT condAl = 4'he;

	localparam logic [1:0] fwdReg = 2'd0;
	localparam logic [1:0] fwdWb = 2'd1;
	localparam logic [1:0] fwdMem = 2'd2;

	// Undefined op with a never-executing condition, decodes to no control
	localparam instrT nopInstr = {4'hf, 3'b111, 41'd0};

	typedef struct packed {
		logic regWrite;
		logic memWrite;
		logic memToReg;
		logic aluSrc;
		aluCmdT aluCmd;
		logic setFlags;
		logic branch;
		condT cond;
	} ctrlT;

	typedef struct packed {
		ctrlT ctrl;
		wordT rnVal;
		wordT rmVal;
		wordT imm;
		regAddrT ra1;
		regAddrT ra2;
		regAddrT wa3;
		wordT pc;
	} deT;

	typedef struct packed {
		logic regWrite;
		logic memWrite;
		logic memToReg;
		wordT aluOut;
		wordT writeData;
		regAddrT wa3;
	} emT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		wordT aluOut;
		wordT readData;
		regAddrT wa3;
	} mwT;

endpackage

// ==== cpuTb.sv ====
`timescale 1ns/10ps

module cpuTb;
	import cpuPkg::*;

	localparam int romWords = 64;
	localparam int waitLimit = 2000;
	// Undefined op under a never-executing condition
	localparam instrT idleWord = {4'hf, 3'd7, 41'd0};

	logic clk;
	logic rstN;
	wordT pcF;
	instrT instr;
	logic memWrite;
	wordT aluOut;
	wordT writeData;
	wordT readData;

	instrT rom [romWords];
	wordT ram [64];
	wordT modelRam [64];
	wordT modelRegs [32];
	instrT prog [$];
	wordT expAddr [$];
	wordT expData [$];
	int errors = 0;
	int failedTests = 0;
	int testCount = 0;
	int storeCount = 0;

	tbClock tbClock_i (.clk(clk));

	cpu cpu_i (
		.clk(clk), .rstN(rstN), .pcF(pcF), .instr(instr), .memWrite(memWrite),
		.aluOut(aluOut), .writeData(writeData), .readData(readData)
	);

	function automatic instrT encode(condT cond, logic [2:0] op, logic [5:0] funct,
			regAddrT rn, regAddrT rd, logic [23:0] imm);
		instrT ins;
		ins = '0;
		ins[47:44] = cond;
		ins[43:41] = op;
		ins[40:35] = funct;
		ins[34:30] = rn;
		ins[29:25] = rd;
		ins[23:0] = imm;
		return ins;
	endfunction

	function automatic instrT dataReg(condT cond, aluCmdT cmd, logic s, regAddrT rd,
			regAddrT rn, regAddrT rm);
		return encode(cond, opData, {1'b0, cmd, s, 2'b00}, rn, rd, {19'd0, rm});
	endfunction

	function automatic instrT dataImm(condT cond, aluCmdT cmd, logic s, regAddrT rd,
			regAddrT rn, logic [23:0] imm);
		return encode(cond, opData, {1'b1, cmd, s, 2'b00}, rn, rd, imm);
	endfunction

	// Store writes rd, load fills rd
	function automatic instrT memOp(condT cond, logic isLoad, regAddrT rd, regAddrT rn,
			logic [23:0] imm);
		return encode(cond, opMem, {4'b1000, isLoad, 1'b0}, rn, rd, imm);
	endfunction

	function automatic instrT branchOp(condT cond, logic [23:0] imm);
		return encode(cond, opBranch, 6'd0, 5'd0, 5'd0, imm);
	endfunction

	function automatic wordT fillWord(int idx);
		return 48'h9e37_79b9_7f4a ^ (wordT'(idx) * 48'h0001_0003_0007);
	endfunction

	function automatic logic condPasses(condT cond, logic n, logic z);
		case (cond)
			condEq: return z;
			condNe: return !z;
			condMi: return n;
			condAl: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic condT pickCond();
		case ($urandom_range(0, 7))
			0: return condEq;
			1: return condNe;
			2: return condMi;
			3: return 4'h9;
			default: return condAl;
		endcase
	endfunction

	function automatic regAddrT randReg();
		return regAddrT'($urandom_range(0, 7));
	endfunction

	task automatic reportMismatch(string sig, wordT got, wordT exp);
		$display("mismatch %s: got %h expected %h", sig, got, exp);
		errors++;
	endtask

	// Program-order interpreter, queues every store it makes
	task automatic runModel(output wordT haltPc, output bit done);
		wordT pc;
		wordT nextPc;
		wordT imm;
		wordT opB;
		wordT res;
		instrT ins;
		logic n;
		logic z;
		logic passes;
		pc = '0;
		n = 1'b0;
		z = 1'b0;
		done = 1'b0;
		haltPc = '1;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		for (int step = 0; step < 500 && !done; step++) begin
			ins = rom[pc[7:2]];
			imm = {{24{ins[23]}}, ins[23:0]};
			passes = condPasses(ins[47:44], n, z);
			nextPc = pc + 48'd4;
			if (ins[43:41] == opBranch && ins[47:44] == condAl && imm == '1) begin
				done = 1'b1;
				haltPc = pc;
			end else if (passes && ins[43:41] == opData) begin
				opB = ins[40] ? imm : modelRegs[ins[4:0]];
				case (ins[39:38])
					aluAdd: res = modelRegs[ins[34:30]] + opB;
					aluSub: res = modelRegs[ins[34:30]] - opB;
					aluAnd: res = modelRegs[ins[34:30]] & opB;
					default: res = modelRegs[ins[34:30]] | opB;
				endcase
				modelRegs[ins[29:25]] = res;
				if (ins[37]) begin
					n = res[47];
					z = (res == '0);
				end
			end else if (passes && ins[43:41] == opMem) begin
				res = modelRegs[ins[34:30]] + imm;
				if (ins[36]) begin
					modelRegs[ins[29:25]] = modelRam[res[7:2]];
				end else begin
					modelRam[res[7:2]] = modelRegs[ins[29:25]];
					expAddr.push_back(res);
					expData.push_back(modelRegs[ins[29:25]]);
				end
			end else if (passes && ins[43:41] == opBranch) begin
				nextPc = pc + 48'd4 + (imm << 2);
			end
			pc = nextPc;
		end
		assert (done) else begin
			$display("reference model never reached the halt branch");
			errors++;
		end
	endtask

	task automatic holdReset(int cycles);
		rstN = 1'b0;
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			@(negedge clk);
			assert (pcF == '0) else reportMismatch("pcF", pcF, '0);
			assert (memWrite == 1'b0) else reportMismatch("memWrite", wordT'(memWrite), '0);
		end
		rstN = 1'b1;
	endtask

	task automatic waitPc(wordT addr, logic equal, output bit ok);
		ok = 1'b0;
		for (int i = 0; i < waitLimit && !ok; i++) begin
			@(negedge clk);
			ok = ((pcF == addr) == equal);
		end
		assert (ok) else begin
			$display("timeout while pcF should %s address %h", equal ? "reach" : "leave", addr);
			errors++;
		end
	endtask

	task automatic finishTest(string name, int errorsBefore);
		testCount++;
		if (errors != errorsBefore) begin
			failedTests++;
		end
		$display("test %0d %s: %s, %0d stores, %0d errors", testCount, name,
			(errors == errorsBefore) ? "ok" : "bad", storeCount, errors - errorsBefore);
	endtask

	task automatic runProgram(string name);
		wordT haltPc;
		int errorsBefore;
		int expected;
		bit ok;
		errorsBefore = errors;
		rstN = 1'b0;
		@(posedge clk);
		// Memories only change while the core sits in reset
		for (int i = 0; i < romWords; i++) begin
			rom[i] = (i < prog.size()) ? prog[i] : idleWord;
			ram[i] = fillWord(i);
			modelRam[i] = fillWord(i);
		end
		runModel(haltPc, ok);
		expected = expAddr.size();
		storeCount = 0;
		holdReset(9);
		// Second arrival at the halt address means the halt branch has executed
		if (ok) begin
			waitPc(haltPc, 1'b1, ok);
		end
		if (ok) begin
			waitPc(haltPc, 1'b0, ok);
		end
		if (ok) begin
			waitPc(haltPc, 1'b1, ok);
		end
		assert (expAddr.size() == 0) else begin
			$display("%0d expected stores never happened", expAddr.size());
			errors++;
		end
		assert (storeCount == expected)
			else reportMismatch("store count", wordT'(storeCount), wordT'(expected));
		expAddr.delete();
		expData.delete();
		finishTest(name, errorsBefore);
	endtask

	task automatic makeRandom(int len);
		int kind;
		logic [23:0] immVal;
		prog.delete();
		for (int k = 0; k < len - 1; k++) begin
			kind = $urandom_range(0, 9);
			immVal = $urandom_range(0, 1) ? 24'($urandom) : 24'($urandom_range(0, 3));
			// Forward only, and never close enough to fetch the halt on a wrong path
			if (kind == 9 && k <= len - 4) begin
				prog.push_back(branchOp(pickCond(), 24'($urandom_range(0, 2))));
			end else if (kind >= 7) begin
				prog.push_back(memOp(pickCond(), kind == 7, randReg(), randReg(), immVal));
			end else if (kind >= 4) begin
				prog.push_back(dataReg(pickCond(), aluCmdT'($urandom_range(0, 3)),
					1'($urandom_range(0, 1)), randReg(), randReg(), randReg()));
			end else begin
				prog.push_back(dataImm(pickCond(), aluCmdT'($urandom_range(0, 3)),
					1'($urandom_range(0, 1)), randReg(), randReg(), immVal));
			end
		end
		prog.push_back(branchOp(condAl, 24'hffffff));
	endtask

	// Memory side of the core, answered on the falling edge
	always @(negedge clk) begin
		if (memWrite === 1'b1) begin
			storeCount++;
			assert (expAddr.size() > 0) else begin
				$display("store to address %h was not expected", aluOut);
				errors++;
			end
			if (expAddr.size() > 0) begin
				assert (aluOut == expAddr[0]) else reportMismatch("aluOut", aluOut, expAddr[0]);
				assert (writeData == expData[0])
					else reportMismatch("writeData", writeData, expData[0]);
				expAddr.delete(0);
				expData.delete(0);
			end
			ram[aluOut[7:2]] = writeData;
		end
		instr = rom[pcF[7:2]];
		readData = ram[aluOut[7:2]];
	end

	initial begin
		int errorsBefore;
		void'($urandom(32'hef72));
		rstN = 1'b0;
		instr = '0;
		readData = '0;
		for (int i = 0; i < romWords; i++) begin
			rom[i] = idleWord;
			ram[i] = fillWord(i);
		end

		errorsBefore = errors;
		holdReset(10);
		for (int i = 1; i <= 3; i++) begin
			@(negedge clk);
			assert (pcF == wordT'(4 * i)) else reportMismatch("pcF", pcF, wordT'(4 * i));
			assert (memWrite == 1'b0) else reportMismatch("memWrite", wordT'(memWrite), '0);
		end
		finishTest("reset", errorsBefore);

		// Back to back dependent ALU ops
		prog = '{
			dataImm(condAl, aluAdd, 1'b0, 5'd1, 5'd0, 24'h000123),
			dataImm(condAl, aluAdd, 1'b0, 5'd2, 5'd1, 24'h000045),
			dataReg(condAl, aluSub, 1'b0, 5'd3, 5'd2, 5'd1),
			dataImm(condAl, aluAnd, 1'b0, 5'd4, 5'd3, 24'h000ff0),
			dataReg(condAl, aluOrr, 1'b0, 5'd5, 5'd4, 5'd2),
			dataImm(condAl, aluSub, 1'b0, 5'd6, 5'd5, 24'hfffff9),
			dataReg(condAl, aluAdd, 1'b0, 5'd7, 5'd6, 5'd4),
			memOp(condAl, 1'b0, 5'd7, 5'd0, 24'd0),
			memOp(condAl, 1'b0, 5'd6, 5'd0, 24'd4),
			memOp(condAl, 1'b0, 5'd5, 5'd0, 24'd8),
			memOp(condAl, 1'b0, 5'd3, 5'd0, 24'd12),
			memOp(condAl, 1'b0, 5'd1, 5'd0, 24'd16),
			branchOp(condAl, 24'hffffff)
		};
		runProgram("alu forwarding");

		prog = '{
			dataImm(condAl, aluAdd, 1'b0, 5'd1, 5'd0, 24'h000040),
			memOp(condAl, 1'b1, 5'd2, 5'd1, 24'h000004),
			dataImm(condAl, aluAdd, 1'b0, 5'd3, 5'd2, 24'h000001),
			memOp(condAl, 1'b0, 5'd3, 5'd0, 24'h000000),
			memOp(condAl, 1'b1, 5'd4, 5'd1, 24'h000008),
			memOp(condAl, 1'b0, 5'd4, 5'd0, 24'h000004),
			memOp(condAl, 1'b1, 5'd5, 5'd0, 24'h000000),
			memOp(condAl, 1'b1, 5'd6, 5'd5, 24'h000000),
			dataReg(condAl, aluOrr, 1'b0, 5'd7, 5'd6, 5'd5),
			memOp(condAl, 1'b0, 5'd7, 5'd0, 24'h000008),
			branchOp(condAl, 24'hffffff)
		};
		runProgram("load use");

		prog = '{
			dataImm(condAl, aluAdd, 1'b0, 5'd1, 5'd0, 24'h000005),
			dataImm(condAl, aluSub, 1'b1, 5'd2, 5'd1, 24'h000005),
			memOp(condEq, 1'b0, 5'd1, 5'd0, 24'd0),
			memOp(condNe, 1'b0, 5'd1, 5'd0, 24'd4),
			memOp(condMi, 1'b0, 5'd1, 5'd0, 24'd8),
			memOp(4'h9, 1'b0, 5'd1, 5'd0, 24'd12),
			dataImm(condAl, aluSub, 1'b1, 5'd3, 5'd0, 24'h000001),
			memOp(condMi, 1'b0, 5'd3, 5'd0, 24'd12),
			memOp(condEq, 1'b0, 5'd3, 5'd0, 24'd16),
			branchOp(condNe, 24'd2),
			memOp(condAl, 1'b0, 5'd1, 5'd0, 24'd20),
			memOp(condAl, 1'b0, 5'd2, 5'd0, 24'd24),
			memOp(condAl, 1'b0, 5'd3, 5'd0, 24'd28),
			branchOp(condEq, 24'd1),
			memOp(condAl, 1'b0, 5'd1, 5'd0, 24'd32),
			branchOp(condMi, 24'd2),
			dataImm(condAl, aluAdd, 1'b0, 5'd7, 5'd0, 24'h000001),
			memOp(condAl, 1'b0, 5'd7, 5'd0, 24'd40),
			memOp(condAl, 1'b0, 5'd7, 5'd0, 24'd36),
			branchOp(condAl, 24'hffffff)
		};
		runProgram("conditional");

		for (int p = 0; p < 5; p++) begin
			makeRandom(40);
			runProgram($sformatf("random program %0d", p));
		end

		$display("tests run %0d, failed %0d, errors %0d", testCount, failedTests, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
	input logic clk,
	input logic rstN,
	input logic flushE,
	input cpuPkg::deT deIn,
	input logic [1:0] forwardA,
	input logic [1:0] forwardB,
	input cpuPkg::wordT aluOutM,
	input cpuPkg::wordT resultW,
	output cpuPkg::emT emOut,
	output cpuPkg::regAddrT raE1,
	output cpuPkg::regAddrT raE2,
	output cpuPkg::regAddrT wa3E,
	output logic memToRegE,
	output logic branchTaken,
	output cpuPkg::wordT branchTarget
);
	import cpuPkg::*;

	deT deE;
	wordT srcA;
	wordT srcB;
	wordT bOp;
	wordT writeDataE;
	wordT aluResult;
	logic [wordWidth:0] sum;
	logic isSub;
	logic isArith;
	flagsT aluFlags;
	flagsT flags;
	logic condEx;

	function automatic wordT fwdMux(logic [1:0] sel, wordT regVal, wordT wbVal,
			wordT memVal);
		case (sel)
			fwdWb: return wbVal;
			fwdMem: return memVal;
			default: return regVal;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rstN || flushE) begin
			deE <= '0;
		end else begin
			deE <= deIn;
		end
	end

	assign srcA = fwdMux(forwardA, deE.rnVal, resultW, aluOutM);
	assign writeDataE = fwdMux(forwardB, deE.rmVal, resultW, aluOutM);
	assign srcB = deE.ctrl.aluSrc ? deE.imm : writeDataE;

	// Subtract as A plus inverted B plus one
	assign isSub = (deE.ctrl.aluCmd == aluSub);
	assign isArith = isSub || (deE.ctrl.aluCmd == aluAdd);
	assign bOp = isSub ? ~srcB : srcB;
	assign sum = {1'b0, srcA} + {1'b0, bOp} + {{wordWidth{1'b0}}, isSub};

	always_comb begin
		case (deE.ctrl.aluCmd)
			aluAnd: aluResult = srcA & srcB;
			aluOrr: aluResult = srcA | srcB;
			default: aluResult = sum[wordWidth-1:0];
		endcase
		aluFlags[flagN] = aluResult[wordWidth-1];
		aluFlags[flagZ] = (aluResult == '0);
		aluFlags[flagC] = isArith && sum[wordWidth];
		aluFlags[flagV] = isArith && (srcA[wordWidth-1] == bOp[wordWidth-1])
			&& (aluResult[wordWidth-1] != srcA[wordWidth-1]);
	end

	always_comb begin
		case (deE.ctrl.cond)
			condEq: condEx = flags[flagZ];
			condNe: condEx = !flags[flagZ];
			condMi: condEx = flags[flagN];
			condAl: condEx = 1'b1;
			default: condEx = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			flags <= '0;
		end else if (deE.ctrl.setFlags && condEx) begin
			flags <= aluFlags;
		end
	end

	assign branchTaken = deE.ctrl.branch && condEx;
	// Target relative to the branch address plus 4, in words
	assign branchTarget = deE.pc + wordT'(4) + (deE.imm << 2);

	assign emOut.regWrite = deE.ctrl.regWrite && condEx;
	assign emOut.memWrite = deE.ctrl.memWrite && condEx;
	assign emOut.memToReg = deE.ctrl.memToReg;
	assign emOut.aluOut = aluResult;
	assign emOut.writeData = writeDataE;
	assign emOut.wa3 = deE.wa3;

	assign raE1 = deE.ra1;
	assign raE2 = deE.ra2;
	assign wa3E = deE.wa3;
	assign memToRegE = deE.ctrl.memToReg;

	fwdLegal: assert property (@(posedge clk) disable iff (!rstN)
		(forwardA != 2'd3) && (forwardB != 2'd3));

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flushD,
	input logic branchTaken,
	input cpuPkg::wordT branchTarget,
	input cpuPkg::instrT instr,
	output cpuPkg::wordT pcF,
	output cpuPkg::instrT instrD,
	output cpuPkg::wordT pcD
);
	import cpuPkg::*;

	wordT pcNext;

	assign pcNext = branchTaken ? branchTarget : pcF + wordT'(4);

	// Redirect beats a stall
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcF <= '0;
		end else if (branchTaken || !stall) begin
			pcF <= pcNext;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN || flushD) begin
			instrD <= nopInstr;
			pcD <= '0;
		end else if (!stall) begin
			instrD <= instr;
			pcD <= pcF;
		end
	end

endmodule

// ==== memStage.sv ====
`timescale 1ns/10ps

module memStage (
	input logic clk,
	input logic rstN,
	input cpuPkg::emT emIn,
	input cpuPkg::wordT readData,
	output logic memWrite,
	output cpuPkg::wordT aluOut,
	output cpuPkg::wordT writeData,
	output logic regWriteM,
	output cpuPkg::regAddrT wa3M,
	output logic regWriteW,
	output cpuPkg::regAddrT wa3W,
	output cpuPkg::wordT resultW
);
	import cpuPkg::*;

	emT emM;
	mwT mwW;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			emM <= '0;
			mwW <= '0;
		end else begin
			emM <= emIn;
			mwW.regWrite <= emM.regWrite;
			mwW.memToReg <= emM.memToReg;
			mwW.aluOut <= emM.aluOut;
			mwW.readData <= readData;
			mwW.wa3 <= emM.wa3;
		end
	end

	// Data memory sees the instruction in M
	assign memWrite = emM.memWrite;
	assign aluOut = emM.aluOut;
	assign writeData = emM.writeData;
	assign regWriteM = emM.regWrite;
	assign wa3M = emM.wa3;

	assign regWriteW = mwW.regWrite;
	assign wa3W = mwW.wa3;
	assign resultW = mwW.memToReg ? mwW.readData : mwW.aluOut;

endmodule

// ==== pipeControl.sv ====
`timescale 1ns/10ps

module pipeControl (
	input logic clk,
	input logic rstN,
	input cpuPkg::instrT instrD,
	input cpuPkg::regAddrT raE1,
	input cpuPkg::regAddrT raE2,
	input logic memToRegE,
	input cpuPkg::regAddrT wa3E,
	input cpuPkg::regAddrT wa3M,
	input cpuPkg::regAddrT wa3W,
	input logic regWriteM,
	input logic regWriteW,
	input logic branchTaken,
	output cpuPkg::ctrlT ctrlD,
	output cpuPkg::wordT immD,
	output cpuPkg::regAddrT ra1D,
	output cpuPkg::regAddrT ra2D,
	output cpuPkg::regAddrT wa3D,
	output logic stall,
	output logic flushD,
	output logic flushE,
	output logic [1:0] forwardA,
	output logic [1:0] forwardB
);
	import cpuPkg::*;

	logic [2:0] op;
	logic isData;
	logic isMem;
	logic isLoad;
	logic useA;
	logic useB;
	logic loadUse;

	function automatic logic [1:0] fwdSel(regAddrT ra, logic weM, regAddrT waM,
			logic weW, regAddrT waW);
		// Youngest producer wins
		if (weM && waM == ra) begin
			return fwdMem;
		end else if (weW && waW == ra) begin
			return fwdWb;
		end
		return fwdReg;
	endfunction

	assign op = instrD[opLsb +: 3];
	assign isData = (op == opData);
	assign isMem = (op == opMem);
	assign isLoad = isMem && instrD[loadBit];

	always_comb begin
		ctrlD = '0;
		ctrlD.cond = instrD[condLsb +: 4];
		if (isData) begin
			ctrlD.regWrite = 1'b1;
			ctrlD.aluSrc = instrD[immSelBit];
			ctrlD.aluCmd = instrD[cmdLsb +: 2];
			ctrlD.setFlags = instrD[setFlagsBit];
		end else if (isMem) begin
			// Address is rn plus immediate
			ctrlD.regWrite = isLoad;
			ctrlD.memWrite = !isLoad;
			ctrlD.memToReg = isLoad;
			ctrlD.aluSrc = 1'b1;
			ctrlD.aluCmd = aluAdd;
		end else if (op == opBranch) begin
			ctrlD.branch = 1'b1;
		end
	end

	assign immD = {{(wordWidth - immMsb - 1){instrD[immMsb]}}, instrD[immMsb:0]};

	// Stores read their data register through the second port
	assign ra1D = instrD[rnLsb +: 5];
	assign ra2D = isMem ? instrD[rdLsb +: 5] : instrD[rmLsb +: 5];
	assign wa3D = instrD[rdLsb +: 5];

	// Only real source operands can cause a load-use stall
	assign useA = isData || isMem;
	assign useB = (isData && !instrD[immSelBit]) || (isMem && !isLoad);
	assign loadUse = memToRegE && ((useA && wa3E == ra1D) || (useB && wa3E == ra2D));

	assign stall = loadUse;
	assign flushD = branchTaken;
	assign flushE = loadUse || branchTaken;

	assign forwardA = fwdSel(raE1, regWriteM, wa3M, regWriteW, wa3W);
	assign forwardB = fwdSel(raE2, regWriteM, wa3M, regWriteW, wa3W);

	// The bubble put into E can never request a second stall
	stallFlush: assert property (@(posedge clk) disable iff (!rstN)
		(stall || branchTaken) |-> flushE ##1 !stall);

endmodule

// ==== regFile.sv ====
`timescale 1ns/10ps

module regFile (
	input logic clk,
	input logic rstN,
	input cpuPkg::regAddrT ra1,
	input cpuPkg::regAddrT ra2,
	output cpuPkg::wordT rd1,
	output cpuPkg::wordT rd2,
	input logic we,
	input cpuPkg::regAddrT wa,
	input cpuPkg::wordT wd
);
	import cpuPkg::*;

	wordT regs [regCount];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// Write-through so decode sees the writeback value in the same cycle
	assign rd1 = (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (we && wa == ra2) ? wd : regs[ra2];

endmodule

// ==== tbClock.sv ====
`timescale 1ns/10ps

module tbClock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// 20 ns period
	always begin
		#10 clk = ~clk;
	end

endmodule
